// File: hdl/core_pkg.sv
package core_pkg;

    // ========================================
    // Core dimensions
    // ========================================

    // Data path and instruction word width
    localparam int XLEN       = 32;
    // Lane count, also the fetch group size
    localparam int NUM_LANES  = 3;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // ========================================
    // Vector types
    // ========================================

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // One bit per lane, bit 0 is the oldest slot
    typedef logic [NUM_LANES-1:0]  lane_mask_t;
    typedef logic [31:0]           count_t;

    // Major opcodes the lanes execute, anything else is a no-op
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // ALU operations shared by OP and OP-IMM
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

// File: hdl/core_ifs.sv
`timescale 1ns/1ps

// Issue slot to lane, one per lane
interface issue_if
    import core_pkg::*;
();
    // Issue event, lanes always accept
    logic  valid;
    word_t instr;
    // Operands read from the register file at issue
    word_t rs1_data;
    word_t rs2_data;
    // Writes a nonzero rd
    logic  dest_we;

    modport issue (output valid, instr, rs1_data, rs2_data, dest_we);
    modport lane  (input  valid, instr, rs1_data, rs2_data, dest_we);
endinterface

// Two read ports of the register file, one pair per lane
interface rf_read_if
    import core_pkg::*;
();
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    // Combinational read data, x0 reads as zero
    word_t     rs1_data;
    word_t     rs2_data;

    modport reader  (output rs1_addr, rs2_addr, input  rs1_data, rs2_data);
    modport regfile (input  rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// Registered lane result, consumed in the cycle it shows up
interface result_if
    import core_pkg::*;
();
    logic      valid;
    logic      we;
    reg_addr_t rd;
    word_t     data;

    modport lane   (output valid, we, rd, data);
    modport retire (input  valid, we, rd, data);
endinterface

// File: hdl/issue_unit.sv
`timescale 1ns/1ps

module issue_unit
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // Three fetch addresses, one aligned group
    output word_t     inst_addr_0_o,
    output word_t     inst_addr_1_o,
    output word_t     inst_addr_2_o,
    input  word_t     instruction_0_i,
    input  word_t     instruction_1_i,
    input  word_t     instruction_2_i,
    issue_if.issue    lanes [NUM_LANES],
    rf_read_if.reader rf [NUM_LANES],
    // Slot 0 held back this cycle
    output logic      issue_stall_o
);

    word_t      pc;
    word_t      instr [NUM_LANES];
    reg_addr_t  rd [NUM_LANES];
    reg_addr_t  rs1 [NUM_LANES];
    reg_addr_t  rs2 [NUM_LANES];
    lane_mask_t use_rs1;
    lane_mask_t use_rs2;
    lane_mask_t writes;
    lane_mask_t hazard;
    lane_mask_t issue;
    lane_mask_t lane_valid;
    logic [1:0] issue_cnt;
    // Writers of the previous cycle, their results are not in the RF yet
    lane_mask_t prev_we;
    reg_addr_t  prev_rd [NUM_LANES];

    // True when a used source register equals r
    function automatic logic src_match(input logic u1, input logic u2,
                                       input reg_addr_t s1, input reg_addr_t s2,
                                       input reg_addr_t r);
        return (u1 && (s1 == r)) || (u2 && (s2 == r));
    endfunction

    // ========================================
    // Fetch group
    // ========================================
    assign inst_addr_0_o = pc;
    assign inst_addr_1_o = pc + 32'd4;
    assign inst_addr_2_o = pc + 32'd8;

    assign instr[0] = instruction_0_i;
    assign instr[1] = instruction_1_i;
    assign instr[2] = instruction_2_i;

    // Register fields and source usage per slot
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            rd[k]      = instr[k][11:7];
            rs1[k]     = instr[k][19:15];
            rs2[k]     = instr[k][24:20];
            use_rs1[k] = (instr[k][6:0] == OPC_OP_IMM) || (instr[k][6:0] == OPC_OP);
            use_rs2[k] = (instr[k][6:0] == OPC_OP);
            // LUI and both ALU groups write, x0 is never a destination
            writes[k]  = (use_rs1[k] || (instr[k][6:0] == OPC_LUI)) && (rd[k] != '0);
        end
    end

    // ========================================
    // Hazard check and issue prefix
    // ========================================
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            hazard[k] = 1'b0;
            for (int j = 0; j < NUM_LANES; j++) begin
                // RAW on last cycle's group
                if (prev_we[j] && src_match(use_rs1[k], use_rs2[k], rs1[k], rs2[k],
                                            prev_rd[j])) begin
                    hazard[k] = 1'b1;
                end
                // RAW on an older slot of this group
                if ((j < k) && writes[j] && src_match(use_rs1[k], use_rs2[k], rs1[k],
                                                      rs2[k], rd[j])) begin
                    hazard[k] = 1'b1;
                end
            end
        end
        // A slot goes only behind all older slots
        issue[0] = !hazard[0];
        for (int k = 1; k < NUM_LANES; k++) begin
            issue[k] = issue[k-1] && !hazard[k];
        end
        issue_cnt = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            issue_cnt = issue_cnt + {1'b0, issue[k]};
        end
    end

    assign issue_stall_o = !issue[0];

    // PC moves by the issued slot count
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc      <= '0;
            prev_we <= '0;
        end else begin
            pc      <= pc + word_t'({issue_cnt, 2'b00});
            prev_we <= issue & writes;
        end
    end

    always_ff @(posedge clk) begin
        prev_rd <= rd;
    end

    // Operand reads and lane hand-off
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_slot
        assign rf[g].rs1_addr    = rs1[g];
        assign rf[g].rs2_addr    = rs2[g];
        assign lanes[g].valid    = issue[g];
        assign lanes[g].instr    = instr[g];
        assign lanes[g].rs1_data = rf[g].rs1_data;
        assign lanes[g].rs2_data = rf[g].rs2_data;
        assign lanes[g].dest_we  = writes[g];
        assign lane_valid[g]     = lanes[g].valid;
    end

    // Lanes see a contiguous run of valids starting at lane 0
    a_valid_prefix : assert property (@(posedge clk) disable iff (!reset)
        (lane_valid & (lane_valid + 1'b1)) == '0);

endmodule

// File: hdl/alu_lane.sv
`timescale 1ns/1ps

module alu_lane
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    issue_if.lane  issue,
    result_if.lane result
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    alu_op_e    op;
    word_t      imm_i;
    word_t      imm_u;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    logic       supported;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_e decode_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ========================================
    // Decode
    // ========================================
    assign opcode    = opcode_e'(issue.instr[6:0]);
    assign funct3    = issue.instr[14:12];
    assign funct7_b5 = issue.instr[30];
    // Sign-extended I-type immediate
    assign imm_i     = {{(XLEN-12){issue.instr[31]}}, issue.instr[31:20]};
    assign imm_u     = {issue.instr[31:12], 12'b0};

    always_comb begin
        op        = ALU_ADD;
        op_a      = issue.rs1_data;
        op_b      = issue.rs2_data;
        supported = 1'b1;
        case (opcode)
            // LUI is 0 + U-immediate
            OPC_LUI: begin
                op_a = '0;
                op_b = imm_u;
            end
            // Bit 30 only matters for SRAI, ADDI never subtracts
            OPC_OP_IMM: begin
                op_b = imm_i;
                op   = decode_op(funct3, (funct3 == 3'b101) && funct7_b5);
            end
            OPC_OP: begin
                op = decode_op(funct3, funct7_b5);
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // ========================================
    // Execute
    // ========================================
    always_comb begin
        case (op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_res = op_a | op_b;
            default:  alu_res = op_a & op_b;
        endcase
    end

    // Result shows one cycle after issue
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result.valid <= 1'b0;
            result.we    <= 1'b0;
        end else begin
            result.valid <= issue.valid;
            result.we    <= issue.valid && issue.dest_we && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            result.rd   <= issue.instr[11:7];
            result.data <= alu_res;
        end
    end

    // A write needs a valid result and a nonzero rd
    a_we_from_issue : assert property (@(posedge clk) disable iff (!reset)
        result.we |-> result.valid && (result.rd != '0));

endmodule

// File: hdl/retire_unit.sv
`timescale 1ns/1ps

module retire_unit
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    result_if.retire    results [NUM_LANES],
    rf_read_if.regfile  rf [NUM_LANES],
    input  logic        issue_stall_i,
    // Writeback view of this cycle's results
    output lane_mask_t  wb_valid_o,
    output lane_mask_t  wb_we_o,
    output reg_addr_t   wb_rd_0_o,
    output reg_addr_t   wb_rd_1_o,
    output reg_addr_t   wb_rd_2_o,
    output word_t       wb_data_0_o,
    output word_t       wb_data_1_o,
    output word_t       wb_data_2_o,
    output count_t      perf_cycles_o,
    output count_t      perf_retired_o,
    output count_t      perf_issue_stalls_o
);

    word_t      regs [NUM_REGS];
    lane_mask_t res_valid;
    lane_mask_t res_we;
    reg_addr_t  res_rd [NUM_LANES];
    word_t      res_data [NUM_LANES];
    // Lane whose write survives, youngest lane wins on a shared rd
    lane_mask_t wins;
    logic [1:0] retire_cnt;

    // ========================================
    // Result collection and RF reads
    // ========================================
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_port
        assign res_valid[g] = results[g].valid;
        assign res_we[g]    = results[g].valid && results[g].we;
        assign res_rd[g]    = results[g].rd;
        assign res_data[g]  = results[g].data;
        // x0 is hardwired to zero
        assign rf[g].rs1_data = (rf[g].rs1_addr == '0) ? '0 : regs[rf[g].rs1_addr];
        assign rf[g].rs2_data = (rf[g].rs2_addr == '0) ? '0 : regs[rf[g].rs2_addr];
    end

    // Results form a run from lane 0 in program order
    a_results_prefix : assert property (@(posedge clk) disable iff (!reset)
        (res_valid & (res_valid + 1'b1)) == '0);

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            wins[k] = res_we[k] && (res_rd[k] != '0);
            for (int j = k + 1; j < NUM_LANES; j++) begin
                if (res_we[j] && (res_rd[j] == res_rd[k])) begin
                    wins[k] = 1'b0;
                end
            end
        end
        retire_cnt = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            retire_cnt = retire_cnt + {1'b0, res_valid[k]};
        end
    end

    // Three write ports
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
                if (wins[k]) begin
                    regs[res_rd[k]] <= res_data[k];
                end
            end
        end
    end

    // ========================================
    // Writeback ports and counters
    // ========================================
    assign wb_valid_o  = res_valid;
    assign wb_we_o     = res_we;
    assign wb_rd_0_o   = res_rd[0];
    assign wb_rd_1_o   = res_rd[1];
    assign wb_rd_2_o   = res_rd[2];
    assign wb_data_0_o = res_data[0];
    assign wb_data_1_o = res_data[1];
    assign wb_data_2_o = res_data[2];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            perf_cycles_o       <= '0;
            perf_retired_o      <= '0;
            perf_issue_stalls_o <= '0;
        end else begin
            perf_cycles_o       <= perf_cycles_o + 32'd1;
            perf_retired_o      <= perf_retired_o + count_t'(retire_cnt);
            perf_issue_stalls_o <= perf_issue_stalls_o + count_t'(issue_stall_i);
        end
    end

endmodule

// File: hdl/rv32i_superscalar_core.sv
`timescale 1ns/1ps

module rv32i_superscalar_core
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output word_t      inst_addr_0_o,
    output word_t      inst_addr_1_o,
    output word_t      inst_addr_2_o,
    input  word_t      instruction_0_i,
    input  word_t      instruction_1_i,
    input  word_t      instruction_2_i,
    output lane_mask_t wb_valid_o,
    output lane_mask_t wb_we_o,
    output reg_addr_t  wb_rd_0_o,
    output reg_addr_t  wb_rd_1_o,
    output reg_addr_t  wb_rd_2_o,
    output word_t      wb_data_0_o,
    output word_t      wb_data_1_o,
    output word_t      wb_data_2_o,
    output count_t     perf_cycles_o,
    output count_t     perf_retired_o,
    output count_t     perf_issue_stalls_o
);

    logic issue_stall;

    // Per-lane buses
    issue_if   issue_bus [NUM_LANES] ();
    rf_read_if rf_bus [NUM_LANES] ();
    result_if  result_bus [NUM_LANES] ();

    // Fetch, hazard check, operand read
    issue_unit u_issue (
        .clk             (clk),
        .reset           (reset),
        .inst_addr_0_o   (inst_addr_0_o),
        .inst_addr_1_o   (inst_addr_1_o),
        .inst_addr_2_o   (inst_addr_2_o),
        .instruction_0_i (instruction_0_i),
        .instruction_1_i (instruction_1_i),
        .instruction_2_i (instruction_2_i),
        .lanes           (issue_bus),
        .rf              (rf_bus),
        .issue_stall_o   (issue_stall)
    );

    // Identical ALU lanes
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        alu_lane u_lane (
            .clk    (clk),
            .reset  (reset),
            .issue  (issue_bus[g]),
            .result (result_bus[g])
        );
    end

    // Register file, writeback, counters
    retire_unit u_retire (
        .clk                 (clk),
        .reset               (reset),
        .results             (result_bus),
        .rf                  (rf_bus),
        .issue_stall_i       (issue_stall),
        .wb_valid_o          (wb_valid_o),
        .wb_we_o             (wb_we_o),
        .wb_rd_0_o           (wb_rd_0_o),
        .wb_rd_1_o           (wb_rd_1_o),
        .wb_rd_2_o           (wb_rd_2_o),
        .wb_data_0_o         (wb_data_0_o),
        .wb_data_1_o         (wb_data_1_o),
        .wb_data_2_o         (wb_data_2_o),
        .perf_cycles_o       (perf_cycles_o),
        .perf_retired_o      (perf_retired_o),
        .perf_issue_stalls_o (perf_issue_stalls_o)
    );

endmodule

// File: verif/tb_core.sv
`timescale 1ns/1ps

module tb_core
    import core_pkg::*;
();

    localparam int    PROG_WORDS = 64;
    localparam word_t END_PC     = 32'(4 * PROG_WORDS);
    localparam int    MAX_CYCLES = 400;

    logic       clk = 1'b0;
    logic       reset = 1'b0;
    word_t      inst_addr [NUM_LANES];
    word_t      instruction [NUM_LANES];
    lane_mask_t wb_valid_o;
    lane_mask_t wb_we_o;
    reg_addr_t  wb_rd [NUM_LANES];
    word_t      wb_data [NUM_LANES];
    count_t     perf_cycles_o;
    count_t     perf_retired_o;
    count_t     perf_issue_stalls_o;

    integer     seed = 32'h39b041cc;
    word_t      prog [PROG_WORDS];
    word_t      model_rf [NUM_REGS];
    word_t      model_pc;
    // Writeback expected in the current cycle
    lane_mask_t exp_valid = '0;
    lane_mask_t exp_we = '0;
    reg_addr_t  exp_rd [NUM_LANES];
    word_t      exp_data [NUM_LANES];
    word_t      exp_pc = '0;
    count_t     exp_cycles = '0;
    count_t     exp_retired = '0;
    count_t     exp_stalls = '0;
    // Group issued this cycle, retires next cycle
    lane_mask_t pend_valid = '0;
    lane_mask_t pend_we = '0;
    reg_addr_t  pend_rd [NUM_LANES];
    word_t      pend_data [NUM_LANES];
    logic       last_stall = 1'b0;
    int         step_no = 0;
    int         dep_stalls = 0;

    always #4 clk = ~clk;

    rv32i_superscalar_core dut0 (
        .clk                 (clk),
        .reset               (reset),
        .inst_addr_0_o       (inst_addr[0]),
        .inst_addr_1_o       (inst_addr[1]),
        .inst_addr_2_o       (inst_addr[2]),
        .instruction_0_i     (instruction[0]),
        .instruction_1_i     (instruction[1]),
        .instruction_2_i     (instruction[2]),
        .wb_valid_o          (wb_valid_o),
        .wb_we_o             (wb_we_o),
        .wb_rd_0_o           (wb_rd[0]),
        .wb_rd_1_o           (wb_rd[1]),
        .wb_rd_2_o           (wb_rd[2]),
        .wb_data_0_o         (wb_data[0]),
        .wb_data_1_o         (wb_data[1]),
        .wb_data_2_o         (wb_data[2]),
        .perf_cycles_o       (perf_cycles_o),
        .perf_retired_o      (perf_retired_o),
        .perf_issue_stalls_o (perf_issue_stalls_o)
    );

    // Instruction memory, zero past the program
    assign instruction[0] = (inst_addr[0] < END_PC) ? prog[inst_addr[0][7:2]] : '0;
    assign instruction[1] = (inst_addr[1] < END_PC) ? prog[inst_addr[1][7:2]] : '0;
    assign instruction[2] = (inst_addr[2] < END_PC) ? prog[inst_addr[2][7:2]] : '0;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic word_t prog_word(input word_t addr);
        if (addr < END_PC) begin
            return prog[addr[7:2]];
        end
        return '0;
    endfunction

    // ========================================
    // Program generation
    // ========================================
    task automatic make_program();
        word_t      r;
        word_t      sel;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        for (int i = 0; i < PROG_WORDS; i++) begin
            sel = $random(seed);
            r   = $random(seed);
            f3  = r[14:12];
            // Registers limited to x0..x7 for frequent hazards
            if (sel[2:0] == 3'd0) begin
                prog[i] = {r[31:12], 2'b00, r[9:7], OPC_LUI};
            end else if (sel[2:0] <= 3'd3) begin
                imm = r[31:20];
                if (f3 == 3'b001) begin
                    imm = {7'b0, r[24:20]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, r[30], 5'b0, r[24:20]};
                end
                prog[i] = {imm, 2'b00, r[17:15], f3, 2'b00, r[9:7], OPC_OP_IMM};
            end else if (sel[2:0] <= 3'd6) begin
                f7 = ((f3 == 3'b000) || (f3 == 3'b101)) ? {1'b0, r[30], 5'b0} : 7'b0;
                prog[i] = {f7, 2'b00, r[22:20], 2'b00, r[17:15], f3, 2'b00, r[9:7], OPC_OP};
            end else begin
                // Branch opcode, unsupported here
                prog[i] = {r[31:7], 7'b1100011};
            end
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    // RV32I result of LUI, OP-IMM or OP
    function automatic word_t isa_result(input word_t w, input word_t a, input word_t b_reg);
        word_t      b;
        logic [2:0] f3;
        logic       alt;
        f3  = w[14:12];
        alt = w[30];
        b   = b_reg;
        if (w[6:0] == OPC_LUI) begin
            return {w[31:12], 12'h000};
        end
        if (w[6:0] == OPC_OP_IMM) begin
            b   = {{20{w[31]}}, w[31:20]};
            alt = (f3 == 3'b101) && w[30];
        end
        case (f3)
            3'b000:  return alt ? (a - b) : (a + b);
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // One cycle of the in-order model
    task automatic model_step();
        word_t      w;
        logic       u1;
        logic       u2;
        logic       wr;
        logic       dep;
        logic       prev_dep;
        logic       blocked;
        lane_mask_t grp_we;
        reg_addr_t  grp_rd [NUM_LANES];
        int         cnt;
        // Counters lag the cycle they count by one edge
        exp_retired = exp_retired + count_t'($countones(exp_valid));
        exp_stalls  = exp_stalls + count_t'(last_stall);
        exp_cycles  = count_t'(step_no);
        step_no++;
        exp_valid = pend_valid;
        exp_we    = pend_we;
        exp_rd    = pend_rd;
        exp_data  = pend_data;
        exp_pc    = model_pc;
        pend_valid = '0;
        pend_we    = '0;
        grp_we     = '0;
        blocked    = 1'b0;
        cnt        = 0;
        for (int k = 0; k < NUM_LANES; k++) begin
            w        = prog_word(model_pc + 32'(4 * k));
            u1       = (w[6:0] == OPC_OP_IMM) || (w[6:0] == OPC_OP);
            u2       = (w[6:0] == OPC_OP);
            wr       = (u1 || (w[6:0] == OPC_LUI)) && (w[11:7] != '0);
            dep      = 1'b0;
            prev_dep = 1'b0;
            for (int j = 0; j < NUM_LANES; j++) begin
                // Last cycle's writes are still in flight
                if (exp_we[j] && ((u1 && (w[19:15] == exp_rd[j])) ||
                                  (u2 && (w[24:20] == exp_rd[j])))) begin
                    prev_dep = 1'b1;
                end
                if ((j < k) && grp_we[j] && ((u1 && (w[19:15] == grp_rd[j])) ||
                                             (u2 && (w[24:20] == grp_rd[j])))) begin
                    dep = 1'b1;
                end
            end
            grp_we[k] = wr;
            grp_rd[k] = w[11:7];
            if (!blocked && !dep && !prev_dep) begin
                pend_valid[k] = 1'b1;
                pend_we[k]    = wr;
                pend_rd[k]    = w[11:7];
                pend_data[k]  = isa_result(w, model_rf[w[19:15]], model_rf[w[24:20]]);
                if (wr) begin
                    model_rf[w[11:7]] = pend_data[k];
                end
                cnt++;
            end else begin
                if ((k == 0) && prev_dep) begin
                    dep_stalls++;
                end
                blocked = 1'b1;
            end
        end
        model_pc   = model_pc + 32'(4 * cnt);
        last_stall = (cnt == 0);
    endtask

    // ========================================
    // Checks, sampled mid-cycle
    // ========================================
    a_reset_state : assert property (@(negedge clk) !reset |->
        (wb_valid_o == '0) && (perf_cycles_o == '0) && (perf_retired_o == '0) &&
        (perf_issue_stalls_o == '0) && (inst_addr[0] == '0))
        else report_fail("reset state wrong: valid, counter or fetch address not zero");

    a_wb_valid : assert property (@(negedge clk) disable iff (!reset)
        wb_valid_o == exp_valid)
        else report_fail($sformatf("mismatch wb_valid_o: got %h expected %h",
                                   wb_valid_o, exp_valid));

    a_wb_we : assert property (@(negedge clk) disable iff (!reset) wb_we_o == exp_we)
        else report_fail($sformatf("mismatch wb_we_o: got %h expected %h", wb_we_o, exp_we));

    a_cycles : assert property (@(negedge clk) disable iff (!reset)
        perf_cycles_o == exp_cycles)
        else report_fail($sformatf("mismatch perf_cycles_o: got %h expected %h",
                                   perf_cycles_o, exp_cycles));

    a_retired : assert property (@(negedge clk) disable iff (!reset)
        perf_retired_o == exp_retired)
        else report_fail($sformatf("mismatch perf_retired_o: got %h expected %h",
                                   perf_retired_o, exp_retired));

    a_stalls : assert property (@(negedge clk) disable iff (!reset)
        perf_issue_stalls_o == exp_stalls)
        else report_fail($sformatf("mismatch perf_issue_stalls_o: got %h expected %h",
                                   perf_issue_stalls_o, exp_stalls));

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_check
        // Fetch group moves one cycle before it retires
        a_fetch_addr : assert property (@(negedge clk) disable iff (!reset)
            inst_addr[g] == exp_pc + word_t'(4 * g))
            else report_fail($sformatf("mismatch inst_addr_%0d_o: got %h expected %h",
                                       g, inst_addr[g], exp_pc + word_t'(4 * g)));
        a_wb_rd : assert property (@(negedge clk) disable iff (!reset)
            exp_we[g] |-> wb_rd[g] == exp_rd[g])
            else report_fail($sformatf("mismatch wb_rd_%0d_o: got %h expected %h",
                                       g, wb_rd[g], exp_rd[g]));
        a_wb_data : assert property (@(negedge clk) disable iff (!reset)
            exp_we[g] |-> wb_data[g] == exp_data[g])
            else report_fail($sformatf("mismatch wb_data_%0d_o: got %h expected %h",
                                       g, wb_data[g], exp_data[g]));
    end

    // ========================================
    // Sequence
    // ========================================
    initial begin
        make_program();
        model_pc = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_rf[r] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b1;
        model_step();
        // Run until the model fetches past the program
        while ((model_pc < END_PC) && (step_no < MAX_CYCLES)) begin
            @(posedge clk);
            #1;
            model_step();
        end
        if (model_pc < END_PC) begin
            report_fail("timeout: program did not drain within the cycle limit");
        end
        // Last issued group still has to retire
        repeat (2) begin
            @(posedge clk);
            #1;
            model_step();
        end
        @(negedge clk);
        #1;
        if (dep_stalls == 0) begin
            report_fail("program never produced a dependency stall");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: compile.f
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/issue_unit.sv
hdl/alu_lane.sv
hdl/retire_unit.sv
hdl/rv32i_superscalar_core.sv
verif/tb_core.sv

// File: run.sh
#!/usr/bin/env bash
# Verilator build of tb_core, then one simulation run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
    -f compile.f -o tb_core &&
./obj_dir/tb_core || exit 1
